// ==== Bender.yml ====
package:
  name: panel_ctrl

sources:
  - include_dirs:
      - .
    files:
      - panel_pkg.sv
      - panel_framebuffer.sv
      - panel_subcmd_fillarea.sv
      - panel_cmd_fillpanel.sv
      - panel_cmd_fillrect.sv
      - panel_cmd_dispatch.sv
      - panel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - panel_tb.sv

// ==== panel_cmd_dispatch.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_cmd_dispatch
    import panel_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 data_in,
    input  logic                       enable,
    input  logic                       fp_ready,
    input  logic                       fp_done,
    input  logic [`ROW_BITS-1:0]       fp_row,
    input  logic [`COLUMN_BITS-1:0]    fp_column,
    input  logic [`PIXEL_SEL_BITS-1:0] fp_pixel,
    input  logic [7:0]                 fp_data,
    input  logic                       fp_write,
    input  logic                       fr_ready,
    input  logic                       fr_done,
    input  logic [`ROW_BITS-1:0]       fr_row,
    input  logic [`COLUMN_BITS-1:0]    fr_column,
    input  logic [`PIXEL_SEL_BITS-1:0] fr_pixel,
    input  logic [7:0]                 fr_data,
    input  logic                       fr_write,
    output logic                       fp_enable,
    output logic                       fr_enable,
    output logic [7:0]                 cmd_data,
    output logic                       ready_for_data,
    output logic                       done,
    output logic [`ROW_BITS-1:0]       row,
    output logic [`COLUMN_BITS-1:0]    column,
    output logic [`PIXEL_SEL_BITS-1:0] pixel,
    output logic [7:0]                 data_out,
    output logic                       ram_write_enable
);
    panel_opcode_t active; // OP_NOP means idle, waiting for an opcode.
    logic is_rect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active <= OP_NOP;
        end else if (active == OP_NOP) begin
            if (enable) begin
                case (panel_opcode_t'(data_in))
                    OP_FILL_PANEL: active <= OP_FILL_PANEL;
                    OP_FILL_RECT:  active <= OP_FILL_RECT;
                    default:       active <= OP_NOP; // NOP and unknown codes.
                endcase
            end
        end else if (done) begin
            active <= OP_NOP;
        end
    end

    assign is_rect = (active == OP_FILL_RECT);

    always_comb begin
        case (active)
            OP_FILL_PANEL: ready_for_data = fp_ready;
            OP_FILL_RECT:  ready_for_data = fr_ready;
            default:       ready_for_data = 1'b1;
        endcase
    end

    assign fp_enable = enable && (active == OP_FILL_PANEL) && fp_ready;
    assign fr_enable = enable && is_rect && fr_ready;
    assign cmd_data  = data_in;
    assign done      = fp_done | fr_done;

    // Write port of the active command.
    assign row              = is_rect ? fr_row : fp_row;
    assign column           = is_rect ? fr_column : fp_column;
    assign pixel            = is_rect ? fr_pixel : fp_pixel;
    assign data_out         = is_rect ? fr_data : fp_data;
    assign ram_write_enable = is_rect ? fr_write : fp_write;

    a_single_writer: assert property (@(posedge clk) disable iff (reset)
        !(fp_write && fr_write));

endmodule

// ==== panel_cmd_fillpanel.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_cmd_fillpanel
    import panel_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 data_in,
    input  logic                       enable,
    output logic [`ROW_BITS-1:0]       row,
    output logic [`COLUMN_BITS-1:0]    column,
    output logic [`PIXEL_SEL_BITS-1:0] pixel,
    output logic [7:0]                 data_out,
    output logic                       ram_write_enable,
    output logic                       ready_for_data,
    output logic                       done
);
    cmd_state_t state;
    logic [`BYTES_PER_PIXEL*8-1:0] color;
    logic [`PIXEL_SEL_BITS-1:0] byte_count;
    logic fill_enable;
    logic local_reset;
    logic fill_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= CMD_CAPTURE;
            byte_count     <= '0;
            fill_enable    <= 1'b0;
            local_reset    <= 1'b0;
            ready_for_data <= 1'b1;
            done           <= 1'b0;
        end else begin
            case (state)
                CMD_CAPTURE: if (enable) begin
                    if (byte_count == `BYTES_PER_PIXEL - 1) begin
                        ready_for_data <= 1'b0;
                        state          <= CMD_START;
                    end
                    byte_count <= byte_count + 1'b1;
                end
                CMD_START: begin
                    fill_enable <= 1'b1;
                    state       <= CMD_RUNNING;
                end
                CMD_RUNNING: if (fill_done) begin
                    fill_enable <= 1'b0;
                    local_reset <= 1'b1; // Return the engine to idle.
                    state       <= CMD_PREDONE;
                end
                CMD_PREDONE: begin
                    local_reset <= 1'b0;
                    done        <= 1'b1;
                    state       <= CMD_DONE;
                end
                default: begin
                    done           <= 1'b0;
                    byte_count     <= '0;
                    ready_for_data <= 1'b1;
                    state          <= CMD_CAPTURE;
                end
            endcase
        end
    end

    // Colour bytes in arrival order.
    always_ff @(posedge clk) begin
        if (state == CMD_CAPTURE && enable)
            color[8*byte_count +: 8] <= data_in;
    end

    panel_subcmd_fillarea i_fillarea (
        .clk              (clk),
        .reset            (reset || local_reset),
        .enable           (fill_enable),
        .ack              (done),
        .x1               (8'd0),
        .y1               (8'd0),
        .width            (8'(`PANEL_WIDTH)),
        .height           (8'(`PANEL_HEIGHT)),
        .color            (color),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .data_out         (data_out),
        .ram_write_enable (ram_write_enable),
        .done             (fill_done)
    );

endmodule

// ==== panel_cmd_fillrect.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_cmd_fillrect
    import panel_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 data_in,
    input  logic                       enable,
    output logic [`ROW_BITS-1:0]       row,
    output logic [`COLUMN_BITS-1:0]    column,
    output logic [`PIXEL_SEL_BITS-1:0] pixel,
    output logic [7:0]                 data_out,
    output logic                       ram_write_enable,
    output logic                       ready_for_data,
    output logic                       done
);
    localparam int OPERAND_BYTES = 4 + `BYTES_PER_PIXEL;

    cmd_state_t state;
    logic [7:0] x1, y1, width, height;
    logic [`BYTES_PER_PIXEL*8-1:0] color;
    logic [2:0] byte_count;
    logic fill_enable;
    logic local_reset;
    logic fill_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= CMD_CAPTURE;
            byte_count     <= '0;
            fill_enable    <= 1'b0;
            local_reset    <= 1'b0;
            ready_for_data <= 1'b1;
            done           <= 1'b0;
        end else begin
            case (state)
                CMD_CAPTURE: if (enable) begin
                    if (byte_count == OPERAND_BYTES - 1) begin
                        ready_for_data <= 1'b0;
                        state          <= CMD_START;
                    end
                    byte_count <= byte_count + 1'b1;
                end
                CMD_START: begin
                    fill_enable <= 1'b1;
                    state       <= CMD_RUNNING;
                end
                CMD_RUNNING: if (fill_done) begin
                    fill_enable <= 1'b0;
                    local_reset <= 1'b1;
                    state       <= CMD_PREDONE;
                end
                CMD_PREDONE: begin
                    local_reset <= 1'b0;
                    done        <= 1'b1;
                    state       <= CMD_DONE;
                end
                default: begin
                    done           <= 1'b0;
                    byte_count     <= '0;
                    ready_for_data <= 1'b1;
                    state          <= CMD_CAPTURE;
                end
            endcase
        end
    end

    // Geometry first, then colour.
    always_ff @(posedge clk) begin
        if (state == CMD_CAPTURE && enable) begin
            case (byte_count)
                3'd0:    x1 <= data_in;
                3'd1:    y1 <= data_in;
                3'd2:    width <= data_in;
                3'd3:    height <= data_in;
                default: color[8*(byte_count - 3'd4) +: 8] <= data_in;
            endcase
        end
    end

    panel_subcmd_fillarea i_fillarea (
        .clk              (clk),
        .reset            (reset || local_reset),
        .enable           (fill_enable),
        .ack              (done),
        .x1               (x1),
        .y1               (y1),
        .width            (width),
        .height           (height),
        .color            (color),
        .row              (row),
        .column           (column),
        .pixel            (pixel),
        .data_out         (data_out),
        .ram_write_enable (ram_write_enable),
        .done             (fill_done)
    );

    a_busy_while_running: assert property (@(posedge clk) disable iff (reset)
        state == CMD_RUNNING |-> !ready_for_data);

endmodule

// ==== panel_defs.svh ====
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Panel geometry
////////////////////////////////////////////////////////////////////////////

`define PANEL_WIDTH 16
`define PANEL_HEIGHT 8
`define BYTES_PER_PIXEL 3 // One byte per colour channel.

// Frame buffer address fields.
`define ROW_BITS 3
`define COLUMN_BITS 4
`define PIXEL_SEL_BITS 2

`endif

// ==== panel_framebuffer.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_framebuffer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`ROW_BITS-1:0]       row,
    input  logic [`COLUMN_BITS-1:0]    column,
    input  logic [`PIXEL_SEL_BITS-1:0] pixel,
    input  logic [7:0]                 data_in,
    input  logic                       write_enable,
    input  logic [`ROW_BITS-1:0]       rd_row,
    input  logic [`COLUMN_BITS-1:0]    rd_column,
    input  logic [`PIXEL_SEL_BITS-1:0] rd_pixel,
    output logic [7:0]                 rd_data
);
    logic [7:0] mem [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < `PANEL_HEIGHT; r++) begin
                for (int c = 0; c < `PANEL_WIDTH; c++) begin
                    for (int p = 0; p < `BYTES_PER_PIXEL; p++) begin
                        mem[r][c][p] <= 8'd0; // Panel starts dark.
                    end
                end
            end
            rd_data <= 8'd0;
        end else begin
            if (write_enable)
                mem[row][column][pixel] <= data_in;
            rd_data <= mem[rd_row][rd_column][rd_pixel];
        end
    end

endmodule

// ==== panel_pkg.sv ====
package panel_pkg;

    // First byte of every host command.
    typedef enum logic [7:0] {
        OP_NOP        = 8'h00,
        OP_FILL_PANEL = 8'h01,
        OP_FILL_RECT  = 8'h02
    } panel_opcode_t;

    typedef enum logic [2:0] {
        CMD_CAPTURE,
        CMD_START,
        CMD_RUNNING,
        CMD_PREDONE,
        CMD_DONE
    } cmd_state_t;

    typedef enum logic [1:0] {FILL_IDLE, FILL_WRITE, FILL_DONE} fill_state_t;

endpackage

// ==== panel_subcmd_fillarea.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_subcmd_fillarea
    import panel_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enable,
    input  logic                          ack,
    input  logic [7:0]                    x1,
    input  logic [7:0]                    y1,
    input  logic [7:0]                    width,
    input  logic [7:0]                    height,
    input  logic [`BYTES_PER_PIXEL*8-1:0] color,
    output logic [`ROW_BITS-1:0]          row,
    output logic [`COLUMN_BITS-1:0]       column,
    output logic [`PIXEL_SEL_BITS-1:0]    pixel,
    output logic [7:0]                    data_out,
    output logic                          ram_write_enable,
    output logic                          done
);
    fill_state_t state;
    logic [8:0] x_end, y_end;   // Exclusive bounds before clipping.
    logic [8:0] x_stop, y_stop; // Exclusive bounds clipped to the panel.
    logic empty;
    logic last_column, last_row, last_pixel;

    ////////////////////////////////////////////////////////////////////////////
    // Clipping
    ////////////////////////////////////////////////////////////////////////////

    assign x_end  = {1'b0, x1} + {1'b0, width};
    assign y_end  = {1'b0, y1} + {1'b0, height};
    assign x_stop = (x_end > `PANEL_WIDTH) ? 9'(`PANEL_WIDTH) : x_end;
    assign y_stop = (y_end > `PANEL_HEIGHT) ? 9'(`PANEL_HEIGHT) : y_end;

    assign empty = (width == 0) || (height == 0)
                || (x1 >= `PANEL_WIDTH) || (y1 >= `PANEL_HEIGHT);

    assign last_pixel  = (pixel == `BYTES_PER_PIXEL - 1);
    assign last_column = ({5'd0, column} == x_stop - 9'd1);
    assign last_row    = ({6'd0, row} == y_stop - 9'd1);

    ////////////////////////////////////////////////////////////////////////////
    // Row-major walk, one byte per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= FILL_IDLE;
            row              <= '0;
            column           <= '0;
            pixel            <= '0;
            ram_write_enable <= 1'b0;
            done             <= 1'b0;
        end else begin
            case (state)
                FILL_IDLE: if (enable) begin
                    if (empty) begin
                        done  <= 1'b1; // Nothing on the panel.
                        state <= FILL_DONE;
                    end else begin
                        row              <= y1[`ROW_BITS-1:0];
                        column           <= x1[`COLUMN_BITS-1:0];
                        pixel            <= '0;
                        ram_write_enable <= 1'b1;
                        state            <= FILL_WRITE;
                    end
                end
                FILL_WRITE: begin
                    if (!last_pixel) begin
                        pixel <= pixel + 1'b1;
                    end else if (!last_column) begin
                        pixel  <= '0;
                        column <= column + 1'b1;
                    end else if (!last_row) begin
                        pixel  <= '0;
                        column <= x1[`COLUMN_BITS-1:0];
                        row    <= row + 1'b1;
                    end else begin
                        ram_write_enable <= 1'b0;
                        done             <= 1'b1;
                        state            <= FILL_DONE;
                    end
                end
                default: if (ack) begin
                    done  <= 1'b0;
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    assign data_out = color[8*pixel +: 8];

    a_write_in_rect: assert property (@(posedge clk) disable iff (reset)
        ram_write_enable |-> pixel < `BYTES_PER_PIXEL
            && {5'd0, column} >= {1'b0, x1} && {5'd0, column} < x_stop
            && {6'd0, row} >= {1'b0, y1} && {6'd0, row} < y_stop);

endmodule

// ==== panel_tb.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_tb
    import panel_pkg::*;
();
    localparam int PANEL_BYTES = `PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL;
    localparam int NUM_FILLS = 13;
    localparam int NUM_SCANS = 15;
    localparam int WATCHDOG_CYCLES =
        2 * (NUM_FILLS * (PANEL_BYTES + 20) + NUM_SCANS * (PANEL_BYTES + 4) + 10);

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic enable;
    logic [`ROW_BITS-1:0] rd_row;
    logic [`COLUMN_BITS-1:0] rd_column;
    logic [`PIXEL_SEL_BITS-1:0] rd_pixel;
    logic ready_for_data;
    logic done;
    logic [7:0] rd_data;

    logic [7:0] model [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];
    logic [31:0] rand_state;
    logic busy; // Last colour byte taken, done not seen yet.
    logic valid_pipe, scan_valid;
    logic [7:0] expect_pipe, scan_expect;
    int errors;
    int fill_count;
    int done_count;
    string test_name;

    panel_top i_panel_top (
        .clk(clk), .reset(reset), .data_in(data_in), .enable(enable),
        .rd_row(rd_row), .rd_column(rd_column), .rd_pixel(rd_pixel),
        .ready_for_data(ready_for_data), .done(done), .rd_data(rd_data)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    // Only the part of the rectangle that lies on the panel changes.
    function automatic void apply_fill(input int x, input int y, input int w, input int h,
                                       input logic [`BYTES_PER_PIXEL*8-1:0] color);
        for (int r = 0; r < `PANEL_HEIGHT; r++)
            for (int c = 0; c < `PANEL_WIDTH; c++)
                if (r >= y && r < y + h && c >= x && c < x + w)
                    for (int p = 0; p < `BYTES_PER_PIXEL; p++)
                        model[r][c][p] = color[8*p +: 8];
    endfunction

    task automatic send_byte(input logic [7:0] value, input logic last);
        @(negedge clk);
        while (!ready_for_data)
            @(negedge clk);
        @(posedge clk);
        data_in <= value;
        enable  <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        if (last)
            busy <= 1'b1;
    endtask

    // Expected byte travels two stages to line up with the registered read.
    task automatic scan_panel();
        for (int r = 0; r < `PANEL_HEIGHT; r++)
            for (int c = 0; c < `PANEL_WIDTH; c++)
                for (int p = 0; p < `BYTES_PER_PIXEL; p++) begin
                    @(posedge clk);
                    rd_row      <= r[`ROW_BITS-1:0];
                    rd_column   <= c[`COLUMN_BITS-1:0];
                    rd_pixel    <= p[`PIXEL_SEL_BITS-1:0];
                    expect_pipe <= model[r][c][p];
                    valid_pipe  <= 1'b1;
                end
        @(posedge clk);
        valid_pipe <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_fill(input string name, input bit rect, input int x, input int y,
                            input int w, input int h);
        logic [31:0] word;
        logic [`BYTES_PER_PIXEL*8-1:0] color;
        word = next_rand();
        color = word[`BYTES_PER_PIXEL*8-1:0];
        test_name = name;
        send_byte(rect ? OP_FILL_RECT : OP_FILL_PANEL, 1'b0);
        if (rect) begin
            send_byte(x[7:0], 1'b0);
            send_byte(y[7:0], 1'b0);
            send_byte(w[7:0], 1'b0);
            send_byte(h[7:0], 1'b0);
        end
        for (int p = 0; p < `BYTES_PER_PIXEL; p++)
            send_byte(color[8*p +: 8], p == `BYTES_PER_PIXEL - 1);
        @(negedge clk);
        while (!done)
            @(negedge clk);
        fill_count++;
        if (rect)
            apply_fill(x, y, w, h, color);
        else
            apply_fill(0, 0, `PANEL_WIDTH, `PANEL_HEIGHT, color);
        scan_panel();
    endtask

    always @(posedge clk) begin
        scan_valid  <= valid_pipe;
        scan_expect <= expect_pipe;
        if (done) begin
            busy       <= 1'b0;
            done_count <= done_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_scan_data: assert property (@(posedge clk) disable iff (reset)
        scan_valid |-> rd_data == scan_expect)
        else begin
            errors++;
            $display("Fail %s expected %h actual %h", test_name, $sampled(scan_expect),
                     $sampled(rd_data));
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            errors++;
            $display("Fail %s done expected 0 actual 1", test_name);
        end

    a_done_expected: assert property (@(posedge clk) disable iff (reset) done |-> busy)
        else begin
            errors++;
            $display("Done pulsed in %s with no fill command pending", test_name);
        end

    a_busy_ready: assert property (@(posedge clk) disable iff (reset)
        busy |-> !ready_for_data)
        else begin
            errors++;
            $display("Fail %s ready_for_data expected 0 actual 1", test_name);
        end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        data_in     = 8'd0;
        enable      = 1'b0;
        rd_row      = '0;
        rd_column   = '0;
        rd_pixel    = '0;
        busy        = 1'b0;
        valid_pipe  = 1'b0;
        scan_valid  = 1'b0;
        expect_pipe = 8'd0;
        scan_expect = 8'd0;
        errors      = 0;
        fill_count  = 0;
        done_count  = 0;
        rand_state  = 32'd90734;
        test_name   = "reset";
        apply_fill(0, 0, `PANEL_WIDTH, `PANEL_HEIGHT, '0); // Panel starts dark.
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (ready_for_data === 1'b1 && done === 1'b0) else begin
            errors++;
            $display("Fail reset ready_for_data,done expected 1,0 actual %b,%b",
                     ready_for_data, done);
        end
        scan_panel();
        run_fill("fill_panel", 1'b0, 0, 0, 0, 0);
        test_name = "ignored_opcodes";
        send_byte(OP_NOP, 1'b0);
        send_byte(8'hA5, 1'b0);
        scan_panel(); // Memory unchanged.
        run_fill("ignored_opcodes", 1'b1, 2, 1, 5, 4);
        run_fill("clip_edge", 1'b1, 12, 5, 10, 9);
        run_fill("zero_width", 1'b1, 3, 2, 0, 4);
        run_fill("zero_height", 1'b1, 3, 2, 4, 0);
        run_fill("off_right", 1'b1, 16, 1, 3, 3);
        run_fill("off_bottom", 1'b1, 0, 8, 5, 2);
        for (int i = 0; i < 6; i++)
            run_fill("random_rect", 1'b1, int'(next_rand() % 20), int'(next_rand() % 12),
                     int'(next_rand() % 12), int'(next_rand() % 8));
        assert (done_count == fill_count) else begin
            errors++;
            $display("Fail done_count expected %0d actual %0d", fill_count, done_count);
        end
        $display("%0d errors, %0d fill commands, %0d done pulses",
                 errors, fill_count, done_count);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a command never completed",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== panel_top.sv ====
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 data_in,
    input  logic                       enable,
    input  logic [`ROW_BITS-1:0]       rd_row,
    input  logic [`COLUMN_BITS-1:0]    rd_column,
    input  logic [`PIXEL_SEL_BITS-1:0] rd_pixel,
    output logic                       ready_for_data,
    output logic                       done,
    output logic [7:0]                 rd_data
);
    logic fp_enable, fp_ready, fp_done, fp_write;
    logic fr_enable, fr_ready, fr_done, fr_write;
    logic [7:0] cmd_data, fp_data, fr_data, wr_data;
    logic [`ROW_BITS-1:0] fp_row, fr_row, wr_row;
    logic [`COLUMN_BITS-1:0] fp_column, fr_column, wr_column;
    logic [`PIXEL_SEL_BITS-1:0] fp_pixel, fr_pixel, wr_pixel;
    logic wr_enable;

    panel_cmd_dispatch i_dispatch (
        .clk(clk), .reset(reset), .data_in(data_in), .enable(enable),
        .fp_ready(fp_ready), .fp_done(fp_done), .fp_row(fp_row),
        .fp_column(fp_column), .fp_pixel(fp_pixel), .fp_data(fp_data),
        .fp_write(fp_write),
        .fr_ready(fr_ready), .fr_done(fr_done), .fr_row(fr_row),
        .fr_column(fr_column), .fr_pixel(fr_pixel), .fr_data(fr_data),
        .fr_write(fr_write),
        .fp_enable(fp_enable), .fr_enable(fr_enable), .cmd_data(cmd_data),
        .ready_for_data(ready_for_data), .done(done),
        .row(wr_row), .column(wr_column), .pixel(wr_pixel),
        .data_out(wr_data), .ram_write_enable(wr_enable)
    );

    panel_cmd_fillpanel i_fillpanel (
        .clk(clk), .reset(reset), .data_in(cmd_data), .enable(fp_enable),
        .row(fp_row), .column(fp_column), .pixel(fp_pixel),
        .data_out(fp_data), .ram_write_enable(fp_write),
        .ready_for_data(fp_ready), .done(fp_done)
    );

    panel_cmd_fillrect i_fillrect (
        .clk(clk), .reset(reset), .data_in(cmd_data), .enable(fr_enable),
        .row(fr_row), .column(fr_column), .pixel(fr_pixel),
        .data_out(fr_data), .ram_write_enable(fr_write),
        .ready_for_data(fr_ready), .done(fr_done)
    );

    panel_framebuffer i_framebuffer (
        .clk(clk), .reset(reset),
        .row(wr_row), .column(wr_column), .pixel(wr_pixel),
        .data_in(wr_data), .write_enable(wr_enable),
        .rd_row(rd_row), .rd_column(rd_column), .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

endmodule

// ==== src.f ====
+incdir+.
panel_pkg.sv
panel_framebuffer.sv
panel_subcmd_fillarea.sv
panel_cmd_fillpanel.sv
panel_cmd_fillrect.sv
panel_cmd_dispatch.sv
panel_top.sv
panel_tb.sv
